// File: design/branch_resolve_if.sv
//############################
// Branch outcome from EX to the BTB
//############################
`include "rv_pipe_cfg.svh"

interface branch_resolve_if;

    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] target;
    logic                taken;
    // Whether fetch predicted this instruction taken
    logic                pred_hit;

    modport execute (output valid, pc, target, taken, pred_hit);
    modport predictor (input valid, pc, target, taken, pred_hit);

endinterface

// File: design/btb_predictor.sv
//############################
// Always-taken BTB with mispredict
// detection and redirect PC
//############################
`include "rv_pipe_cfg.svh"

module btb_predictor (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [`RV_XLEN-1:0] fetch_pc_i,
    output logic                pred_hit_o,
    output logic [`RV_XLEN-1:0] pred_target_o,
    output logic                redirect_o,
    output logic [`RV_XLEN-1:0] redirect_pc_o,
    branch_resolve_if.predictor resolve
);

    localparam int ENTRIES = 1 << `RV_BTB_INDEX_W;
    localparam int TAG_W   = `RV_XLEN - `RV_BTB_INDEX_W - 2;

    logic [ENTRIES-1:0]  valid_q;
    logic [TAG_W-1:0]    tag_q    [0:ENTRIES-1];
    logic [`RV_XLEN-1:0] target_q [0:ENTRIES-1];

    logic [`RV_BTB_INDEX_W-1:0] rd_index, wr_index;
    logic [TAG_W-1:0]           rd_tag, wr_tag;

    assign rd_index = fetch_pc_i[`RV_BTB_INDEX_W+1:2];
    assign rd_tag   = fetch_pc_i[`RV_XLEN-1:`RV_BTB_INDEX_W+2];
    assign wr_index = resolve.pc[`RV_BTB_INDEX_W+1:2];
    assign wr_tag   = resolve.pc[`RV_XLEN-1:`RV_BTB_INDEX_W+2];

    // A hit means predict taken
    assign pred_hit_o    = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign pred_target_o = target_q[rd_index];

    // Prediction and outcome disagree
    assign redirect_o    = resolve.valid && (resolve.pred_hit != resolve.taken);
    assign redirect_pc_o = resolve.taken ? resolve.target : resolve.pc + `RV_XLEN'd4;

    // Taken outcomes allocate; not-taken ones leave the entry alone
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (resolve.valid && resolve.taken) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (resolve.valid && resolve.taken) begin
            tag_q[wr_index]    <= wr_tag;
            target_q[wr_index] <= resolve.target;
        end
    end

    // An entry still tagged with this PC holds the target EX computes
    hit_target_a: assert property (@(posedge clk_i) disable iff (rst_i)
        resolve.valid && resolve.pred_hit && valid_q[wr_index] && tag_q[wr_index] == wr_tag
            |-> target_q[wr_index] == resolve.target);

endmodule

// File: design/decode_stage.sv
//############################
// Control decode, immediates, register file
// and the ID/EX register
//############################
`include "rv_pipe_cfg.svh"

module decode_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  rv_pipe_pkg::if_id_t if_id_i,
    input  logic                flush_i,
    input  rv_pipe_pkg::wb_t    wb_i,
    output rv_pipe_pkg::id_ex_t id_ex_o
);

    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0]       regs_q [0:31];
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [`RV_XLEN-1:0]       rs1_val, rs2_val, imm;
    ctrl_t                     ctrl;

    assign opcode = if_id_i.instr[6:0];
    assign funct3 = if_id_i.instr[14:12];
    assign rd     = if_id_i.instr[11:7];
    assign rs1    = if_id_i.instr[19:15];
    assign rs2    = if_id_i.instr[24:20];

    // Shared by OP and OP-IMM; sub only set for register ops
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  alu_sel = sub ? ALU_SUB : ALU_ADD;
            3'b010:  alu_sel = ALU_SLT;
            3'b100:  alu_sel = ALU_XOR;
            3'b110:  alu_sel = ALU_OR;
            3'b111:  alu_sel = ALU_AND;
            default: alu_sel = ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        imm  = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = alu_sel(funct3, if_id_i.instr[30]);
                ctrl.reg_wr = (rd != '0);
            end
            OPC_OP_IMM: begin
                ctrl.alu_op  = alu_sel(funct3, 1'b0);
                ctrl.use_imm = 1'b1;
                ctrl.reg_wr  = (rd != '0);
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_ne     = funct3[0];
                imm = {{19{if_id_i.instr[31]}}, if_id_i.instr[31], if_id_i.instr[7],
                       if_id_i.instr[30:25], if_id_i.instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.reg_wr = (rd != '0);
                imm = {{11{if_id_i.instr[31]}}, if_id_i.instr[31], if_id_i.instr[19:12],
                       if_id_i.instr[20], if_id_i.instr[30:21], 1'b0};
            end
            default: ctrl = '0;
        endcase
    end

    // x0 reads as zero, a write landing this edge is bypassed
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb_i.reg_wr && wb_i.rd == rs1) ? wb_i.data : regs_q[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb_i.reg_wr && wb_i.rd == rs2) ? wb_i.data : regs_q[rs2];

    always_ff @(posedge clk_i) begin
        if (wb_i.reg_wr) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid   <= if_id_i.valid && !flush_i;
            id_ex_o.ctrl    <= ctrl;
            id_ex_o.pc      <= if_id_i.pc;
            id_ex_o.rs1     <= rs1;
            id_ex_o.rs2     <= rs2;
            id_ex_o.rd      <= rd;
            id_ex_o.rs1_val <= rs1_val;
            id_ex_o.rs2_val <= rs2_val;
            id_ex_o.imm     <= imm;
            id_ex_o.btb_hit <= if_id_i.btb_hit;
        end
    end

    supported_instr_a: assert property (@(posedge clk_i) disable iff (rst_i)
        if_id_i.valid |-> (opcode inside {OPC_OP, OPC_OP_IMM, OPC_BRANCH, OPC_JAL})
            && (opcode != OPC_BRANCH || funct3[2:1] == 2'b00));

endmodule

// File: design/execute_stage.sv
//############################
// Forwarding, ALU, branch resolution and
// the EX/MEM and MEM/WB registers
//############################
`include "rv_pipe_cfg.svh"

module execute_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  rv_pipe_pkg::id_ex_t id_ex_i,
    branch_resolve_if.execute   resolve,
    output rv_pipe_pkg::wb_t    wb_o
);

    import rv_pipe_pkg::*;

    wb_t                 ex_mem_q;
    logic [`RV_XLEN-1:0] op_a, op_b, alu_b, alu_res, target, link_pc;
    logic                taken;

    // Only real register writes are forwarded
    function automatic logic fwd_match(input wb_t stage,
                                       input logic [`RV_REG_ADDR_W-1:0] rs);
        fwd_match = stage.reg_wr && (stage.rd != '0) && (stage.rd == rs);
    endfunction

    // EX/MEM is younger, so it goes first
    assign op_a = fwd_match(ex_mem_q, id_ex_i.rs1) ? ex_mem_q.data :
                  fwd_match(wb_o, id_ex_i.rs1)     ? wb_o.data : id_ex_i.rs1_val;
    assign op_b = fwd_match(ex_mem_q, id_ex_i.rs2) ? ex_mem_q.data :
                  fwd_match(wb_o, id_ex_i.rs2)     ? wb_o.data : id_ex_i.rs2_val;

    assign alu_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : op_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
            ALU_XOR: alu_res = op_a ^ alu_b;
            ALU_SLT: alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_res = op_a + alu_b;
        endcase
    end

    // BEQ on equality, BNE on its inverse; JAL always goes
    assign taken   = id_ex_i.ctrl.is_jal ||
                     (id_ex_i.ctrl.is_branch && ((op_a == op_b) != id_ex_i.ctrl.br_ne));
    assign target  = id_ex_i.pc + id_ex_i.imm;
    assign link_pc = id_ex_i.pc + `RV_XLEN'd4;

    assign resolve.valid    = id_ex_i.valid && (id_ex_i.ctrl.is_branch || id_ex_i.ctrl.is_jal);
    assign resolve.pc       = id_ex_i.pc;
    assign resolve.target   = target;
    assign resolve.taken    = taken;
    assign resolve.pred_hit = id_ex_i.btb_hit;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ex_mem_q <= '0;
            wb_o     <= '0;
        end else begin
            ex_mem_q.reg_wr <= id_ex_i.valid && id_ex_i.ctrl.reg_wr;
            ex_mem_q.rd     <= id_ex_i.rd;
            ex_mem_q.data   <= id_ex_i.ctrl.is_jal ? link_pc : alu_res;
            // No memory access, MEM just delays the result
            wb_o            <= ex_mem_q;
        end
    end

endmodule

// File: design/fetch_stage.sv
//############################
// PC, next-PC select and IF/ID register
//############################
`include "rv_pipe_cfg.svh"

module fetch_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                run_i,
    input  logic [`RV_XLEN-1:0] instr_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output rv_pipe_pkg::if_id_t if_id_o,
    output logic                flush_o,
    branch_resolve_if.predictor resolve
);

    logic                pred_hit, redirect;
    logic [`RV_XLEN-1:0] pred_target, redirect_pc, pc_q, next_pc;

    btb_predictor btb_predictor_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_pc_i    (pc_q),
        .pred_hit_o    (pred_hit),
        .pred_target_o (pred_target),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .resolve       (resolve)
    );

    // Redirect wins over the BTB, which wins over PC+4
    assign next_pc = redirect ? redirect_pc :
                     pred_hit ? pred_target : pc_q + `RV_XLEN'd4;

    assign pc_o    = pc_q;
    assign flush_o = redirect;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc_q    <= '0;
            if_id_o <= '0;
        end else begin
            // Parked at zero while stopped
            pc_q            <= run_i ? next_pc : '0;
            if_id_o.valid   <= run_i && !redirect;
            if_id_o.pc      <= pc_q;
            if_id_o.instr   <= instr_i;
            if_id_o.btb_hit <= pred_hit;
        end
    end

endmodule

// File: design/program_store.sv
//############################
// Instruction memory, loaded by a four-phase
// req/ack port and read by fetch
//############################
`include "rv_pipe_cfg.svh"

module program_store (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       ld_req_i,
    input  logic [`RV_IMEM_ADDR_W-1:0] ld_addr_i,
    input  logic [`RV_XLEN-1:0]        ld_data_i,
    output logic                       ld_ack_o,
    input  logic                       run_i,
    input  logic [`RV_XLEN-1:0]        fetch_pc_i,
    output logic [`RV_XLEN-1:0]        fetch_instr_o
);

    logic [`RV_XLEN-1:0] mem_q [0:(1 << `RV_IMEM_ADDR_W)-1];

    // Slave side: write and ack on req, release ack once req drops
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ld_ack_o <= 1'b0;
        end else if (ld_req_i && !ld_ack_o) begin
            ld_ack_o <= 1'b1;
        end else if (!ld_req_i && ld_ack_o) begin
            ld_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_req_i && !ld_ack_o) begin
            mem_q[ld_addr_i] <= ld_data_i;
        end
    end

    // Word address from the byte PC
    assign fetch_instr_o = mem_q[fetch_pc_i[`RV_IMEM_ADDR_W+1:2]];

    // Req may only drop once ack is up
    req_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(ld_req_i) |-> ld_ack_o);

    word_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        ld_req_i && $past(ld_req_i) |-> $stable(ld_addr_i) && $stable(ld_data_i));

    load_stopped_a: assert property (@(posedge clk_i) disable iff (rst_i)
        ld_req_i |-> !run_i);

endmodule

// File: design/rv_pipe_pkg.sv
//############################
// Opcodes, ALU ops and pipeline register types
//############################
`include "rv_pipe_cfg.svh"

package rv_pipe_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Decoded control, travels with the instruction into EX
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_wr;
        logic    is_branch;
        logic    is_jal;
        logic    br_ne;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
        logic                btb_hit;
    } if_id_t;

    typedef struct packed {
        logic                      valid;
        ctrl_t                     ctrl;
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       rs1_val;
        logic [`RV_XLEN-1:0]       rs2_val;
        logic [`RV_XLEN-1:0]       imm;
        logic                      btb_hit;
    } id_ex_t;

    // Shared by EX/MEM and MEM/WB
    typedef struct packed {
        logic                      reg_wr;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
    } wb_t;

endpackage

// File: design/rv_pipe_top.sv
//############################
// Five-stage RV32I pipeline with program
// load port and writeback observation
//############################
`include "rv_pipe_cfg.svh"

module rv_pipe_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       run_i,
    input  logic                       ld_req_i,
    input  logic [`RV_IMEM_ADDR_W-1:0] ld_addr_i,
    input  logic [`RV_XLEN-1:0]        ld_data_i,
    output logic                       ld_ack_o,
    output logic                       wb_valid_o,
    output logic [`RV_REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`RV_XLEN-1:0]        wb_data_o
);

    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0] fetch_pc, fetch_instr;
    logic                flush;
    if_id_t              if_id;
    id_ex_t              id_ex;
    wb_t                 mem_wb;

    branch_resolve_if resolve_if ();

    program_store program_store_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ld_req_i      (ld_req_i),
        .ld_addr_i     (ld_addr_i),
        .ld_data_i     (ld_data_i),
        .ld_ack_o      (ld_ack_o),
        .run_i         (run_i),
        .fetch_pc_i    (fetch_pc),
        .fetch_instr_o (fetch_instr)
    );

    fetch_stage fetch_stage_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .run_i   (run_i),
        .instr_i (fetch_instr),
        .pc_o    (fetch_pc),
        .if_id_o (if_id),
        .flush_o (flush),
        .resolve (resolve_if.predictor)
    );

    decode_stage decode_stage_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .if_id_i (if_id),
        .flush_i (flush),
        .wb_i    (mem_wb),
        .id_ex_o (id_ex)
    );

    execute_stage execute_stage_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .id_ex_i (id_ex),
        .resolve (resolve_if.execute),
        .wb_o    (mem_wb)
    );

    // Decode never sets reg_wr for x0
    assign wb_valid_o = mem_wb.reg_wr;
    assign wb_rd_o    = mem_wb.rd;
    assign wb_data_o  = mem_wb.data;

endmodule

// File: include/rv_pipe_cfg.svh
//############################
// Sizing macros for the RV32I pipeline
// Included by the package and each RTL file
//############################
`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

// Data and address width
`define RV_XLEN        32
`define RV_REG_ADDR_W  5

// 64-entry direct-mapped BTB
`define RV_BTB_INDEX_W 6

// Program store holds 256 words
`define RV_IMEM_ADDR_W 8

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the pipeline testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f rv_pipe_top.f --top-module rv_pipe_tb -o rv_pipe_sim

# The simulator exit code is ignored, the log decides
./obj_dir/rv_pipe_sim > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION PASSED" sim.log

// File: rv_pipe_top.f
+incdir+include
design/rv_pipe_pkg.sv
design/branch_resolve_if.sv
design/program_store.sv
design/btb_predictor.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/rv_pipe_top.sv
tb/rv_pipe_tb.sv

// File: tb/rv_pipe_tb.sv
//##############################
// Testbench for the RV32I pipeline. Loads each program from
// the table, runs it and checks the writeback stream in order
//##############################
`include "rv_pipe_cfg.svh"

module rv_pipe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_PROGS = 3;
    localparam logic [31:0] NOP       = 32'h00000013;

    // Expected writeback as {rd, data}
    typedef logic [`RV_REG_ADDR_W+`RV_XLEN-1:0] wb_pair_t;

    logic                       clk_i = 1'b0;
    logic                       rst_i, run_i, ld_req_i, ld_ack_o, wb_valid_o;
    logic [`RV_IMEM_ADDR_W-1:0] ld_addr_i;
    logic [`RV_XLEN-1:0]        ld_data_i, wb_data_o;
    logic [`RV_REG_ADDR_W-1:0]  wb_rd_o;

    logic [31:0] prog_q [NUM_PROGS][$];
    wb_pair_t    exp_q  [NUM_PROGS][$];

    rv_pipe_top rv_pipe_top_i (.*);

    always #2 clk_i = ~clk_i;

    // RV32I encoders for the program table
    function automatic logic [31:0] enc_r(int f3, int rd, int rs1, int rs2, bit sub);
        return {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(int f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(int rd, int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic stop_run(string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "Testbench stopped on the first error");
    endtask

    // Lands 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic fill_table();
        // ALU chain at forwarding distances 1 to 4, plus a write to x0
        prog_q[0] = '{enc_i(0, 1, 0, 5), enc_i(0, 2, 1, 7), enc_r(0, 3, 1, 2, 0),
            enc_r(0, 4, 3, 1, 1), enc_r(4, 5, 4, 1, 0), enc_r(6, 6, 5, 3, 0),
            enc_r(7, 7, 6, 4, 0), enc_i(0, 9, 0, -3), enc_r(2, 10, 9, 7, 0),
            enc_i(2, 11, 7, 9), enc_i(4, 12, 10, -1), enc_i(7, 13, 12, 'hF0),
            enc_i(6, 14, 13, 'hF), enc_r(0, 0, 1, 2, 0), enc_r(0, 15, 0, 1, 0), enc_j(0, 0)};
        exp_q[0] = '{{5'd1, 32'd5}, {5'd2, 32'd12}, {5'd3, 32'd17}, {5'd4, 32'd12},
            {5'd5, 32'd9}, {5'd6, 32'd25}, {5'd7, 32'd8}, {5'd9, 32'hFFFFFFFD},
            {5'd10, 32'd1}, {5'd11, 32'd1}, {5'd12, 32'hFFFFFFFE}, {5'd13, 32'hF0},
            {5'd14, 32'hFF}, {5'd15, 32'd5}};
        // Count to 4 with BNE, shadow ADDIs retire only on exit
        prog_q[1] = '{enc_i(0, 1, 0, 0), enc_i(0, 2, 0, 4), enc_i(0, 1, 1, 1),
            enc_b(1, 1, 2, -4), enc_i(0, 3, 0, 7), enc_i(0, 4, 0, 9), enc_j(0, 0)};
        exp_q[1] = '{{5'd1, 32'd0}, {5'd2, 32'd4}, {5'd1, 32'd1}, {5'd1, 32'd2},
            {5'd1, 32'd3}, {5'd1, 32'd4}, {5'd3, 32'd7}, {5'd4, 32'd9}};
        // JAL link and skip, taken BEQ skip, then a not-taken BEQ
        prog_q[2] = '{enc_i(0, 1, 0, 3), enc_j(5, 12), enc_i(0, 1, 0, 100),
            enc_i(0, 2, 0, 100), enc_i(0, 2, 1, 1), enc_i(0, 6, 0, 4), enc_b(0, 2, 6, 12),
            enc_i(0, 7, 0, 55), enc_i(0, 8, 0, 66), enc_r(0, 9, 2, 5, 0),
            enc_b(0, 9, 1, 8), enc_i(4, 10, 9, 5), enc_j(0, 0)};
        exp_q[2] = '{{5'd1, 32'd3}, {5'd5, 32'd8}, {5'd2, 32'd4}, {5'd6, 32'd4},
            {5'd9, 32'd12}, {5'd10, 32'd9}};
    endtask

    // Master side of the four-phase load handshake
    task automatic load_word(int addr, logic [31:0] data);
        int n;
        ld_addr_i = addr[`RV_IMEM_ADDR_W-1:0];
        ld_data_i = data;
        assert (!ld_ack_o) else stop_run($sformatf(
            "[FAIL] %0d ns: load ack high before req rose", $time));
        ld_req_i = 1'b1;
        n = 0;
        while (!ld_ack_o) begin
            next_cycle();
            n++;
            assert (!wb_valid_o) else stop_run($sformatf(
                "[FAIL] %0d ns: writeback seen while run_i was low", $time));
            assert (n < 10) else stop_run("Timeout waiting for load ack to rise");
        end
        // Ack has to stay up while req is still held
        next_cycle();
        assert (ld_ack_o) else stop_run($sformatf(
            "[FAIL] %0d ns: load ack fell before req dropped", $time));
        ld_req_i = 1'b0;
        n = 0;
        while (ld_ack_o) begin
            next_cycle();
            n++;
            assert (n < 10) else stop_run("Timeout waiting for load ack to fall");
        end
    endtask

    task automatic check_writebacks(int p);
        int       n;
        wb_pair_t exp;
        for (int k = 0; k < exp_q[p].size(); k++) begin
            exp = exp_q[p][k];
            n = 0;
            do begin
                next_cycle();
                n++;
                assert (n < 100) else stop_run($sformatf(
                    "Timeout waiting for writeback %0d of program %0d", k, p));
            end while (!wb_valid_o);
            assert ({wb_rd_o, wb_data_o} == exp) else stop_run($sformatf(
                "[FAIL] %0d ns: program %0d writeback %0d got x%0d=%h, expected x%0d=%h",
                $time, p, k, wb_rd_o, wb_data_o, exp[`RV_REG_ADDR_W+`RV_XLEN-1:`RV_XLEN],
                exp[`RV_XLEN-1:0]));
        end
        // Self-loop reached, nothing more may retire
        repeat (20) begin
            next_cycle();
            assert (!wb_valid_o) else stop_run($sformatf(
                "[FAIL] %0d ns: program %0d extra writeback x%0d=%h",
                $time, p, wb_rd_o, wb_data_o));
        end
    endtask

    initial begin
        rst_i     = 1'b1;
        run_i     = 1'b0;
        ld_req_i  = 1'b0;
        ld_addr_i = '0;
        ld_data_i = '0;
        fill_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_i = 1'b0;
            rst_i = 1'b1;
            repeat (2) next_cycle();
            rst_i = 1'b0;
            assert (!ld_ack_o && !wb_valid_o) else stop_run($sformatf(
                "[FAIL] %0d ns: ack or writeback high after reset", $time));
            // Trailing NOPs cover fetches past the final self-loop
            for (int a = 0; a < prog_q[p].size() + 4; a++) begin
                load_word(a, (a < prog_q[p].size()) ? prog_q[p][a] : NOP);
            end
            repeat (4) begin
                next_cycle();
                assert (!wb_valid_o) else stop_run($sformatf(
                    "[FAIL] %0d ns: writeback seen while run_i was low", $time));
            end
            run_i = 1'b1;
            check_writebacks(p);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
